// ==== rtl/y86_pkg.sv ====
package y86_pkg;

    localparam logic [3:0] IHALT   = 4'h0;
    localparam logic [3:0] INOP    = 4'h1;
    localparam logic [3:0] IRRMOVQ = 4'h2; // also the cmovXX family.
    localparam logic [3:0] IIRMOVQ = 4'h3;
    localparam logic [3:0] IRMMOVQ = 4'h4;
    localparam logic [3:0] IMRMOVQ = 4'h5;
    localparam logic [3:0] IOPQ    = 4'h6;
    localparam logic [3:0] IJXX    = 4'h7;
    localparam logic [3:0] ICALL   = 4'h8;
    localparam logic [3:0] IRET    = 4'h9;
    localparam logic [3:0] IPUSHQ  = 4'hA;
    localparam logic [3:0] IPOPQ   = 4'hB;

    localparam logic [3:0] ALUADD = 4'h0;
    localparam logic [3:0] ALUSUB = 4'h1;
    localparam logic [3:0] ALUAND = 4'h2;
    localparam logic [3:0] ALUXOR = 4'h3;

    localparam logic [3:0] C_YES = 4'h0;
    localparam logic [3:0] C_LE  = 4'h1;
    localparam logic [3:0] C_L   = 4'h2;
    localparam logic [3:0] C_E   = 4'h3;
    localparam logic [3:0] C_NE  = 4'h4;
    localparam logic [3:0] C_GE  = 4'h5;
    localparam logic [3:0] C_G   = 4'h6;

    localparam logic [2:0] SAOK = 3'd1;
    localparam logic [2:0] SHLT = 3'd2;
    localparam logic [2:0] SADR = 3'd3;
    localparam logic [2:0] SINS = 3'd4;

    localparam logic [3:0] RNONE = 4'hF;

    localparam logic [2:0] CC_RESET = 3'b100; // {zf, sf, of}.

    typedef struct packed {
        logic [2:0]  stat;
        logic [3:0]  icode;
        logic [3:0]  ifun;
        logic [3:0]  dstE;
        logic [63:0] valA;
        logic [63:0] valB;
        logic [63:0] valC;
    } e_payload_t;

    typedef struct packed {
        logic [2:0]  stat;
        logic [3:0]  icode;
        logic        cnd;
        logic [63:0] valE;
        logic [63:0] valA;
        logic [3:0]  dstE;
    } m_payload_t;

    localparam e_payload_t E_BUBBLE = '{stat: SAOK, icode: INOP, ifun: 4'h0, dstE: RNONE,
                                        valA: 64'h0, valB: 64'h0, valC: 64'h0};
    localparam m_payload_t M_BUBBLE = '{stat: SAOK, icode: INOP, cnd: 1'b0, valE: 64'h0,
                                        valA: 64'h0, dstE: RNONE};

endpackage

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    parameter type      payload_t = logic [63:0],
    parameter payload_t BUBBLE    = payload_t'('0)
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q_r;

    // bubble wins over stall, so a squashed slot never keeps a stale instruction.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || bubble_i) begin
            q_r <= BUBBLE;
        end else if (!stall_i) begin
            q_r <= d_i;
        end
    end

    assign q_o = q_r;

endmodule

// ==== rtl/alu_path.sv ====
`timescale 1ns/100ps

module alu_path import y86_pkg::*; (
    input  logic        [3:0]  icode_i,
    input  logic        [3:0]  ifun_i,
    input  logic signed [63:0] valA_i,
    input  logic signed [63:0] valB_i,
    input  logic signed [63:0] valC_i,
    output logic        [63:0] valE_o,
    output logic               new_zf_o,
    output logic               new_sf_o,
    output logic               new_of_o
);

    logic signed [63:0] alu_a;
    logic signed [63:0] alu_b;
    logic        [3:0]  alu_fun;
    logic signed [63:0] result;

    always_comb begin
        case (icode_i)
            IRRMOVQ, IOPQ:            alu_a = valA_i;
            IIRMOVQ, IRMMOVQ, IMRMOVQ: alu_a = valC_i; // displacement or immediate.
            ICALL, IPUSHQ:            alu_a = -64'sd8;
            IRET, IPOPQ:              alu_a = 64'sd8;
            default:                  alu_a = 64'sd0;
        endcase
    end

    always_comb begin
        case (icode_i)
            IRMMOVQ, IMRMOVQ, IOPQ, ICALL, IPUSHQ, IRET, IPOPQ: alu_b = valB_i;
            default:                                            alu_b = 64'sd0;
        endcase
    end

    assign alu_fun = (icode_i == IOPQ) ? ifun_i : ALUADD;

    always_comb begin
        case (alu_fun)
            ALUSUB:  result = alu_b - alu_a;
            ALUAND:  result = alu_b & alu_a;
            ALUXOR:  result = alu_b ^ alu_a;
            default: result = alu_b + alu_a;
        endcase
    end

    // overflow means the operand signs allowed it and the result sign disagrees.
    always_comb begin
        case (alu_fun)
            ALUSUB:         new_of_o = (alu_a[63] != alu_b[63]) && (result[63] != alu_b[63]);
            ALUAND, ALUXOR: new_of_o = 1'b0;
            default:        new_of_o = (alu_a[63] == alu_b[63]) && (result[63] != alu_a[63]);
        endcase
    end

    assign new_zf_o = (result == 64'sd0);
    assign new_sf_o = result[63];
    assign valE_o   = result;

endmodule

// ==== rtl/cond_unit.sv ====
`timescale 1ns/100ps

module cond_unit import y86_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic [3:0] icode_i,
    input  logic [3:0] ifun_i,
    input  logic       new_zf_i,
    input  logic       new_sf_i,
    input  logic       new_of_i,
    input  logic [2:0] m_stat_i,
    input  logic [2:0] W_stat_i,
    output logic       cnd_o
);

    logic [2:0] cc_q; // {zf, sf, of}.
    logic       set_cc;
    logic       zf;
    logic       sf;
    logic       of;

    // an exception further down the pipe must not leave its mark on the flags.
    assign set_cc = (icode_i == IOPQ) && !stall_i
                    && (m_stat_i == SAOK) && (W_stat_i == SAOK);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cc_q <= CC_RESET;
        end else if (set_cc) begin
            cc_q <= {new_zf_i, new_sf_i, new_of_i};
        end
    end

    assign zf = cc_q[2];
    assign sf = cc_q[1];
    assign of = cc_q[0];

    always_comb begin
        case (ifun_i)
            C_YES:   cnd_o = 1'b1;
            C_LE:    cnd_o = (sf ^ of) | zf;
            C_L:     cnd_o = sf ^ of;
            C_E:     cnd_o = zf;
            C_NE:    cnd_o = !zf;
            C_GE:    cnd_o = !(sf ^ of);
            C_G:     cnd_o = !(sf ^ of) && !zf;
            default: cnd_o = 1'b0;
        endcase
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import y86_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic        [2:0]  stat_i,
    input  logic        [3:0]  icode_i,
    input  logic        [3:0]  ifun_i,
    input  logic        [3:0]  dstE_i,
    input  logic signed [63:0] valA_i,
    input  logic signed [63:0] valB_i,
    input  logic signed [63:0] valC_i,
    input  logic        [2:0]  m_stat_i,
    input  logic        [2:0]  W_stat_i,
    output logic        [63:0] valE_o,
    output logic        [3:0]  dstE_o,
    output logic               cnd_o,
    output logic        [2:0]  stat_o
);

    logic new_zf;
    logic new_sf;
    logic new_of;

    alu_path u_alu (
        .icode_i  (icode_i),
        .ifun_i   (ifun_i),
        .valA_i   (valA_i),
        .valB_i   (valB_i),
        .valC_i   (valC_i),
        .valE_o   (valE_o),
        .new_zf_o (new_zf),
        .new_sf_o (new_sf),
        .new_of_o (new_of)
    );

    cond_unit u_cc (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .icode_i  (icode_i),
        .ifun_i   (ifun_i),
        .new_zf_i (new_zf),
        .new_sf_i (new_sf),
        .new_of_i (new_of),
        .m_stat_i (m_stat_i),
        .W_stat_i (W_stat_i),
        .cnd_o    (cnd_o)
    );

    // a cmov whose condition fails still flows on, it just writes nothing.
    assign dstE_o = ((icode_i == IRRMOVQ) && !cnd_o) ? RNONE : dstE_i;
    assign stat_o = stat_i;

endmodule

// ==== rtl/execute_top.sv ====
`timescale 1ns/100ps

module execute_top import y86_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        bubble_i,
    input  logic [2:0]  d_stat_i,
    input  logic [3:0]  d_icode_i,
    input  logic [3:0]  d_ifun_i,
    input  logic [3:0]  d_dstE_i,
    input  logic [63:0] d_valA_i,
    input  logic [63:0] d_valB_i,
    input  logic [63:0] d_valC_i,
    input  logic [2:0]  m_stat_i,
    input  logic [2:0]  W_stat_i,
    output logic [63:0] e_valE_o,
    output logic [3:0]  e_dstE_o,
    output logic [2:0]  m_stat_o,
    output logic [3:0]  m_icode_o,
    output logic        m_cnd_o,
    output logic [63:0] m_valE_o,
    output logic [63:0] m_valA_o,
    output logic [3:0]  m_dstE_o
);

    e_payload_t e_d;
    e_payload_t e_q;
    m_payload_t m_d;
    m_payload_t m_q;
    logic       e_cnd;
    logic [2:0] e_stat;

    assign e_d = '{stat: d_stat_i, icode: d_icode_i, ifun: d_ifun_i, dstE: d_dstE_i,
                   valA: d_valA_i, valB: d_valB_i, valC: d_valC_i};

    pipe_reg #(.payload_t(e_payload_t), .BUBBLE(E_BUBBLE)) u_ereg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .bubble_i (bubble_i),
        .d_i      (e_d),
        .q_o      (e_q)
    );

    execute_stage u_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .stat_i   (e_q.stat),
        .icode_i  (e_q.icode),
        .ifun_i   (e_q.ifun),
        .dstE_i   (e_q.dstE),
        .valA_i   (e_q.valA),
        .valB_i   (e_q.valB),
        .valC_i   (e_q.valC),
        .m_stat_i (m_stat_i),
        .W_stat_i (W_stat_i),
        .valE_o   (e_valE_o),
        .dstE_o   (e_dstE_o),
        .cnd_o    (e_cnd),
        .stat_o   (e_stat)
    );

    assign m_d = '{stat: e_stat, icode: e_q.icode, cnd: e_cnd, valE: e_valE_o,
                   valA: e_q.valA, dstE: e_dstE_o};

    // a held E instruction must reach M only once, so stall inserts a bubble here.
    pipe_reg #(.payload_t(m_payload_t), .BUBBLE(M_BUBBLE)) u_mreg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (1'b0),
        .bubble_i (stall_i),
        .d_i      (m_d),
        .q_o      (m_q)
    );

    assign m_stat_o  = m_q.stat;
    assign m_icode_o = m_q.icode;
    assign m_cnd_o   = m_q.cnd;
    assign m_valE_o  = m_q.valE;
    assign m_valA_o  = m_q.valA;
    assign m_dstE_o  = m_q.dstE;

endmodule

// ==== bench/execute_checker.sv ====
`timescale 1ns/100ps

module execute_checker import y86_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        bubble_i,
    input  logic [2:0]  d_stat_i,
    input  logic [3:0]  d_icode_i,
    input  logic [3:0]  d_ifun_i,
    input  logic [3:0]  d_dstE_i,
    input  logic [63:0] d_valA_i,
    input  logic [63:0] d_valB_i,
    input  logic [63:0] d_valC_i,
    input  logic [2:0]  m_stat_i,
    input  logic [2:0]  W_stat_i,
    input  logic [2:0]  out_stat_i,
    input  logic [3:0]  out_icode_i,
    input  logic        out_cnd_i,
    input  logic [63:0] out_valE_i,
    input  logic [63:0] out_valA_i,
    input  logic [3:0]  out_dstE_i,
    input  logic [63:0] fwd_valE_i,
    input  logic [3:0]  fwd_dstE_i,
    output int          err_cnt_o,
    output int          chk_cnt_o
);

    e_payload_t e_model;
    m_payload_t m_model;
    logic [2:0] cc_model; // {zf, sf, of}.
    logic       started = 1'b0;

    // returns {of, result}, with overflow taken from a one bit wider signed sum.
    function automatic logic [64:0] exec_alu(input logic [3:0] icode, input logic [3:0] ifun,
                                             input logic [63:0] va, input logic [63:0] vb,
                                             input logic [63:0] vc);
        logic [63:0] a;
        logic [63:0] b;
        logic [64:0] wide;
        logic [3:0]  fn;
        logic        of;
        a = 64'd0;
        b = 64'd0;
        of = 1'b0;
        if (icode == IRRMOVQ || icode == IOPQ) a = va;
        else if (icode inside {IIRMOVQ, IRMMOVQ, IMRMOVQ}) a = vc;
        else if (icode == ICALL || icode == IPUSHQ) a = 64'hFFFF_FFFF_FFFF_FFF8;
        else if (icode == IRET || icode == IPOPQ) a = 64'd8;
        if (icode inside {IRMMOVQ, IMRMOVQ, IOPQ, ICALL, IPUSHQ, IRET, IPOPQ}) b = vb;
        fn = (icode == IOPQ) ? ifun : ALUADD;
        case (fn)
            ALUSUB: begin
                wide = {b[63], b} - {a[63], a};
                of = wide[64] ^ wide[63];
            end
            ALUAND:  wide = {1'b0, b & a};
            ALUXOR:  wide = {1'b0, b ^ a};
            default: begin
                wide = {b[63], b} + {a[63], a};
                of = wide[64] ^ wide[63];
            end
        endcase
        return {of, wide[63:0]};
    endfunction

    function automatic logic cond_holds(input logic [3:0] ifun, input logic [2:0] cc);
        logic lt;
        lt = cc[1] ^ cc[0]; // signed less than.
        case (ifun)
            C_YES:   return 1'b1;
            C_LE:    return lt | cc[2];
            C_L:     return lt;
            C_E:     return cc[2];
            C_NE:    return !cc[2];
            C_GE:    return !lt;
            C_G:     return !lt && !cc[2];
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    always @(posedge clk_i) begin
        logic [64:0] alu;
        logic        cnd;
        alu = exec_alu(e_model.icode, e_model.ifun, e_model.valA, e_model.valB, e_model.valC);
        cnd = cond_holds(e_model.ifun, cc_model);
        if (!rst_n_i || stall_i) begin
            m_model = M_BUBBLE;
        end else begin
            m_model.stat  = e_model.stat;
            m_model.icode = e_model.icode;
            m_model.cnd   = cnd;
            m_model.valE  = alu[63:0];
            m_model.valA  = e_model.valA;
            m_model.dstE  = (e_model.icode == IRRMOVQ && !cnd) ? RNONE : e_model.dstE;
        end
        if (!rst_n_i) begin
            cc_model = 3'b100;
        end else if (e_model.icode == IOPQ && !stall_i && m_stat_i == SAOK
                     && W_stat_i == SAOK) begin
            cc_model = {alu[63:0] == 64'd0, alu[63], alu[64]};
        end
        if (!rst_n_i || bubble_i) begin
            e_model = E_BUBBLE;
        end else if (!stall_i) begin
            e_model = '{stat: d_stat_i, icode: d_icode_i, ifun: d_ifun_i, dstE: d_dstE_i,
                        valA: d_valA_i, valB: d_valB_i, valC: d_valC_i};
        end
        started = 1'b1;
    end

    always @(negedge clk_i) begin
        logic [64:0] e_alu;
        logic        e_cnd;
        logic [3:0]  e_dst;
        if (started) begin
            e_alu = exec_alu(e_model.icode, e_model.ifun, e_model.valA, e_model.valB,
                             e_model.valC);
            e_cnd = cond_holds(e_model.ifun, cc_model);
            e_dst = (e_model.icode == IRRMOVQ && !e_cnd) ? RNONE : e_model.dstE;
            compare_field("m_stat_o", out_stat_i, m_model.stat);
            compare_field("m_icode_o", out_icode_i, m_model.icode);
            compare_field("m_cnd_o", out_cnd_i, m_model.cnd);
            compare_field("m_valE_o", out_valE_i, m_model.valE);
            compare_field("m_valA_o", out_valA_i, m_model.valA);
            compare_field("m_dstE_o", out_dstE_i, m_model.dstE);
            compare_field("e_valE_o", fwd_valE_i, e_alu[63:0]);
            compare_field("e_dstE_o", fwd_dstE_i, e_dst);
            chk_cnt_o++;
        end
    end

endmodule

// ==== bench/execute_asserts.sv ====
`timescale 1ns/100ps

module execute_asserts import y86_pkg::*; (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       stall_i,
    input logic [3:0] m_icode_i,
    input logic       m_cnd_i,
    input logic [3:0] m_dstE_i,
    input logic [2:0] cc_i
);

    int fail_cnt = 0;

    cmov_cancelled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m_icode_i == IRRMOVQ && !m_cnd_i) |-> (m_dstE_i == RNONE))
        else begin
            $error("failed cmov still carries a destination register");
            fail_cnt++;
        end

    stall_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> (m_icode_i == INOP && m_dstE_i == RNONE))
        else begin
            $error("M register did not take a bubble after a stall");
            fail_cnt++;
        end

    stall_keeps_cc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(cc_i))
        else begin
            $error("condition codes changed during a stall");
            fail_cnt++;
        end

endmodule

bind execute_top execute_asserts u_asserts (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall_i),
    .m_icode_i (m_icode_o),
    .m_cnd_i   (m_cnd_o),
    .m_dstE_i  (m_dstE_o),
    .cc_i      (u_stage.u_cc.cc_q)
);

// ==== bench/execute_tb.sv ====
`timescale 1ns/100ps

module execute_tb import y86_pkg::*; ();

    localparam int NUM_CYCLES = 3000;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        bubble;
    logic [2:0]  d_stat;
    logic [3:0]  d_icode;
    logic [3:0]  d_ifun;
    logic [3:0]  d_dstE;
    logic [63:0] d_valA;
    logic [63:0] d_valB;
    logic [63:0] d_valC;
    logic [2:0]  m_stat_in;
    logic [2:0]  w_stat_in;
    logic [63:0] e_valE;
    logic [3:0]  e_dstE;
    logic [2:0]  m_stat;
    logic [3:0]  m_icode;
    logic        m_cnd;
    logic [63:0] m_valE;
    logic [63:0] m_valA;
    logic [3:0]  m_dstE;
    int          err_cnt;
    int          chk_cnt;
    int          timeouts = 0;
    logic [15:0] lfsr = 16'd24789;

    execute_top u_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .stall_i   (stall),
        .bubble_i  (bubble),
        .d_stat_i  (d_stat),
        .d_icode_i (d_icode),
        .d_ifun_i  (d_ifun),
        .d_dstE_i  (d_dstE),
        .d_valA_i  (d_valA),
        .d_valB_i  (d_valB),
        .d_valC_i  (d_valC),
        .m_stat_i  (m_stat_in),
        .W_stat_i  (w_stat_in),
        .e_valE_o  (e_valE),
        .e_dstE_o  (e_dstE),
        .m_stat_o  (m_stat),
        .m_icode_o (m_icode),
        .m_cnd_o   (m_cnd),
        .m_valE_o  (m_valE),
        .m_valA_o  (m_valA),
        .m_dstE_o  (m_dstE)
    );

    execute_checker u_chk (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .stall_i     (stall),
        .bubble_i    (bubble),
        .d_stat_i    (d_stat),
        .d_icode_i   (d_icode),
        .d_ifun_i    (d_ifun),
        .d_dstE_i    (d_dstE),
        .d_valA_i    (d_valA),
        .d_valB_i    (d_valB),
        .d_valC_i    (d_valC),
        .m_stat_i    (m_stat_in),
        .W_stat_i    (w_stat_in),
        .out_stat_i  (m_stat),
        .out_icode_i (m_icode),
        .out_cnd_i   (m_cnd),
        .out_valE_i  (m_valE),
        .out_valA_i  (m_valA),
        .out_dstE_i  (m_dstE),
        .fwd_valE_i  (e_valE),
        .fwd_dstE_i  (e_dstE),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken.
    task automatic draw(input int nbits, output logic [63:0] v);
        v = 64'd0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic pick_operand(output logic [63:0] v);
        logic [63:0] sel;
        draw(3, sel);
        if (sel == 0) begin
            draw(2, sel); // sign boundary values drive the overflow cases.
            case (sel[1:0])
                2'd0:    v = 64'h7FFF_FFFF_FFFF_FFFF;
                2'd1:    v = 64'h8000_0000_0000_0000;
                2'd2:    v = 64'h0000_0000_0000_0001;
                default: v = 64'hFFFF_FFFF_FFFF_FFFF;
            endcase
        end else begin
            draw(64, v);
        end
    endtask

    task automatic drive_random();
        logic [63:0] r;
        draw(4, r);
        if (r < 5) d_icode = IOPQ;
        else if (r < 8) d_icode = IRRMOVQ;
        else if (r < 11) d_icode = IJXX;
        else begin
            draw(4, r);
            d_icode = 4'(r % 12);
        end
        draw(3, r);
        d_ifun = (d_icode == IOPQ) ? {2'b00, r[1:0]} : {1'b0, r[2:0]}; // valid ALU codes only.
        draw(4, r);
        d_dstE = r[3:0];
        pick_operand(d_valA);
        pick_operand(d_valB);
        pick_operand(d_valC);
        draw(3, r);
        d_stat = (r == 0) ? SADR : ((r == 1) ? SINS : SAOK);
        draw(3, r);
        stall = (r == 0);
        draw(3, r);
        bubble = (r == 0);
        draw(3, r);
        m_stat_in = (r == 0) ? SADR : SAOK;
        draw(3, r);
        w_stat_in = (r == 0) ? SHLT : SAOK;
    endtask

    task automatic drive_idle();
        {stall, bubble} = 2'b00;
        {d_stat, d_icode, d_ifun, d_dstE} = {SAOK, INOP, 4'h0, RNONE};
        {d_valA, d_valB, d_valC} = '0;
        m_stat_in = SAOK;
        w_stat_in = SAOK;
    endtask

    task automatic wait_m_empty(input string what);
        int n;
        for (n = 0; n < 16; n++) begin
            @(negedge clk);
            if (m_icode === INOP && m_dstE === RNONE) break;
        end
        if (n == 16) begin
            $display("timeout: M register never emptied while waiting for %s", what);
            timeouts++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        wait_m_empty("the end of reset");
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #1 drive_random();
        end
        @(posedge clk);
        #1 drive_idle();
        wait_m_empty("the final drain");
        @(posedge clk);
        #1;
        $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 chk_cnt, err_cnt, u_dut.u_asserts.fail_cnt, timeouts);
        if (err_cnt == 0 && u_dut.u_asserts.fail_cnt == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/y86_pkg.sv
rtl/pipe_reg.sv
rtl/alu_path.sv
rtl/cond_unit.sv
rtl/execute_stage.sv
rtl/execute_top.sv
bench/execute_checker.sv
bench/execute_asserts.sv
bench/execute_tb.sv

// ==== Bender.yml ====
package:
  name: y86_execute

sources:
  - rtl/y86_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/alu_path.sv
  - rtl/cond_unit.sv
  - rtl/execute_stage.sv
  - rtl/execute_top.sv
  - target: test
    files:
      - bench/execute_checker.sv
      - bench/execute_asserts.sv
      - bench/execute_tb.sv
